/* hw/ex_pkg.sv */
package ex_pkg;

    localparam int xlen = 64;
    localparam int reg_addr_w = 5;
    localparam int csr_addr_w = 12;

    typedef enum logic [4:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_addw,
        alu_subw,
        alu_sllw,
        alu_srlw,
        alu_sraw,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [3:0] {
        mdu_mul,
        mdu_mulh,
        mdu_mulhsu,
        mdu_mulhu,
        mdu_div,
        mdu_divu,
        mdu_rem,
        mdu_remu,
        mdu_mulw,
        mdu_divw,
        mdu_divuw,
        mdu_remw,
        mdu_remuw
    } mdu_op_e;

    typedef enum logic [1:0] {
        sel_rs2,
        sel_four,
        sel_imm,
        sel_csr
    } src_b_e;

    // Unsigned compares reuse blt/bge with branch_unsigned set.
    typedef enum logic [2:0] {
        br_none,
        br_jal,
        br_jalr,
        br_beq,
        br_bne,
        br_blt,
        br_bge
    } branch_e;

    // Same coding as funct3 of the load/store instructions.
    typedef enum logic [2:0] {
        mem_b,
        mem_h,
        mem_w,
        mem_d,
        mem_bu,
        mem_hu,
        mem_wu
    } mem_op_e;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       src1;
        logic [xlen-1:0]       src2;
        logic [31:0]           imm;
        logic [xlen-1:0]       csr_data;
        logic [csr_addr_w-1:0] csr_addr;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic                  src_a_pc;
        src_b_e                src_b;
        logic                  use_mdu;
        alu_op_e               alu_op;
        mdu_op_e               mdu_op;
        branch_e               branch;
        logic                  branch_unsigned;
        mem_op_e               mem_op;
        logic                  mem_rd;
        logic                  mem_wr;
        logic                  reg_wr;
        logic                  csr;
        logic                  ecall;
        logic                  mret;
        logic                  done;
        logic                  error;
    } ex_issue_t;

    typedef struct packed {
        logic [xlen-1:0]       result;
        logic [xlen-1:0]       nxtpc;
        logic                  is_jmp;
        logic [reg_addr_w-1:0] rd;
        logic [csr_addr_w-1:0] csr_addr;
        mem_op_e               mem_op;
        logic                  mem_rd;
        logic                  mem_wr;
        logic                  reg_wr;
        logic                  csr;
        logic                  ecall;
        logic                  mret;
        logic                  done;
        logic                  error;
    } ex_result_t;

endpackage

/* hw/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [63:0]     a,
    input  logic [63:0]     b,
    input  ex_pkg::alu_op_e op,
    output logic [63:0]     result,
    output logic            zero
);

    logic [31:0] word_res;

    // Word operations, low 32 bits only.
    always_comb begin
        case (op)
            ex_pkg::alu_addw: begin
                word_res = a[31:0] + b[31:0];
            end
            ex_pkg::alu_subw: begin
                word_res = a[31:0] - b[31:0];
            end
            ex_pkg::alu_sllw: begin
                word_res = a[31:0] << b[4:0];
            end
            ex_pkg::alu_srlw: begin
                word_res = a[31:0] >> b[4:0];
            end
            ex_pkg::alu_sraw: begin
                word_res = $signed(a[31:0]) >>> b[4:0];
            end
            default: begin
                word_res = 32'b0;
            end
        endcase
    end

    always_comb begin
        case (op)
            ex_pkg::alu_add:    result = a + b;
            ex_pkg::alu_sub:    result = a - b;
            ex_pkg::alu_sll:    result = a << b[5:0];
            ex_pkg::alu_slt:    result = {63'b0, $signed(a) < $signed(b)};
            ex_pkg::alu_sltu:   result = {63'b0, a < b};
            ex_pkg::alu_xor:    result = a ^ b;
            ex_pkg::alu_srl:    result = a >> b[5:0];
            ex_pkg::alu_sra:    result = $signed(a) >>> b[5:0];
            ex_pkg::alu_or:     result = a | b;
            ex_pkg::alu_and:    result = a & b;
            ex_pkg::alu_pass_b: result = b;
            ex_pkg::alu_addw,
            ex_pkg::alu_subw,
            ex_pkg::alu_sllw,
            ex_pkg::alu_srlw,
            ex_pkg::alu_sraw: begin
                result = {{32{word_res[31]}}, word_res};
            end
            default:            result = 64'b0;
        endcase
    end

    // Branches on equality read this after a sub.
    assign zero = (result == 64'b0);

endmodule

/* hw/mul_div_unit.sv */
`timescale 1ns/1ps

module mul_div_unit (
    input  logic [63:0]     src1,
    input  logic [63:0]     src2,
    input  ex_pkg::mdu_op_e op,
    output logic [63:0]     result,
    output logic            error
);

    logic [127:0]       prod;
    logic [63:0]        hi_su;
    logic [63:0]        hi_ss;
    logic               div_zero;
    logic               div_zero_w;
    logic               div_ovf;
    logic               div_ovf_w;
    logic [63:0]        divisor_s;
    logic [63:0]        divisor_u;
    logic [31:0]        divisor_sw;
    logic [31:0]        divisor_uw;
    logic signed [63:0] quot_s;
    logic signed [63:0] rem_s;
    logic signed [31:0] quot_sw;
    logic signed [31:0] rem_sw;
    logic [63:0]        quot_u;
    logic [63:0]        rem_u;
    logic [31:0]        quot_uw;
    logic [31:0]        rem_uw;

    // One unsigned multiplier. Signed high halves are corrected from it.
    assign prod = {64'b0, src1} * {64'b0, src2};
    assign hi_su = prod[127:64] - (src1[63] ? src2 : 64'b0);
    assign hi_ss = hi_su - (src2[63] ? src1 : 64'b0);

    assign div_zero = (src2 == 64'b0);
    assign div_zero_w = (src2[31:0] == 32'b0);
    assign div_ovf = (src1 == {1'b1, 63'b0}) && (src2 == {64{1'b1}});
    assign div_ovf_w = (src1[31:0] == {1'b1, 31'b0}) && (src2[31:0] == {32{1'b1}});

    // Dividing by one yields the overflow results directly.
    assign divisor_s = (div_zero || div_ovf) ? 64'd1 : src2;
    assign divisor_u = div_zero ? 64'd1 : src2;
    assign divisor_sw = (div_zero_w || div_ovf_w) ? 32'd1 : src2[31:0];
    assign divisor_uw = div_zero_w ? 32'd1 : src2[31:0];

    assign quot_s = $signed(src1) / $signed(divisor_s);
    assign rem_s = $signed(src1) % $signed(divisor_s);
    assign quot_sw = $signed(src1[31:0]) / $signed(divisor_sw);
    assign rem_sw = $signed(src1[31:0]) % $signed(divisor_sw);
    assign quot_u = src1 / divisor_u;
    assign rem_u = src1 % divisor_u;
    assign quot_uw = src1[31:0] / divisor_uw;
    assign rem_uw = src1[31:0] % divisor_uw;

    always_comb begin
        error = 1'b0;
        case (op)
            ex_pkg::mdu_mul:    result = prod[63:0];
            ex_pkg::mdu_mulh:   result = hi_ss;
            ex_pkg::mdu_mulhsu: result = hi_su;
            ex_pkg::mdu_mulhu:  result = prod[127:64];
            ex_pkg::mdu_div:    result = div_zero ? {64{1'b1}} : quot_s;
            ex_pkg::mdu_divu:   result = div_zero ? {64{1'b1}} : quot_u;
            ex_pkg::mdu_rem:    result = div_zero ? src1 : rem_s;
            ex_pkg::mdu_remu:   result = div_zero ? src1 : rem_u;
            ex_pkg::mdu_mulw:   result = {{32{prod[31]}}, prod[31:0]};
            ex_pkg::mdu_divw:   result = div_zero_w ? {64{1'b1}} : {{32{quot_sw[31]}}, quot_sw};
            ex_pkg::mdu_divuw:  result = div_zero_w ? {64{1'b1}} : {{32{quot_uw[31]}}, quot_uw};
            ex_pkg::mdu_remw: begin
                result = div_zero_w ? {{32{src1[31]}}, src1[31:0]} : {{32{rem_sw[31]}}, rem_sw};
            end
            ex_pkg::mdu_remuw: begin
                result = div_zero_w ? {{32{src1[31]}}, src1[31:0]} : {{32{rem_uw[31]}}, rem_uw};
            end
            default: begin
                result = 64'b0;
                error = 1'b1;
            end
        endcase
    end

    // Decoder coverage must track the enum list.
    always_comb begin
        if (!error) begin
            a_legal_op: assert (op.name() != "");
        end
    end

endmodule

/* hw/next_pc.sv */
`timescale 1ns/1ps

module next_pc (
    input  logic [63:0]     pc,
    input  logic [63:0]     rs1_val,
    input  logic [63:0]     imm,
    input  logic            zero,
    input  logic            lt,
    input  ex_pkg::branch_e branch,
    input  logic            branch_unsigned,
    output logic [63:0]     nxtpc,
    output logic            taken
);

    logic [63:0] pc_imm;
    logic [63:0] jalr_target;
    logic        ordered;
    logic        cond;

    assign pc_imm = pc + imm;
    assign jalr_target = (rs1_val + imm) & ~64'h1;

    // Unsigned flag is only defined for the ordered compares.
    assign ordered = (branch == ex_pkg::br_blt) || (branch == ex_pkg::br_bge);

    always_comb begin
        case (branch)
            ex_pkg::br_beq: cond = zero;
            ex_pkg::br_bne: cond = !zero;
            ex_pkg::br_blt: cond = lt;
            ex_pkg::br_bge: cond = !lt;
            default:        cond = 1'b0;
        endcase
        if (branch_unsigned && !ordered) begin
            cond = 1'b0;
        end
    end

    always_comb begin
        case (branch)
            ex_pkg::br_jal: begin
                taken = 1'b1;
                nxtpc = pc_imm;
            end
            ex_pkg::br_jalr: begin
                taken = 1'b1;
                nxtpc = jalr_target;
            end
            default: begin
                taken = cond;
                nxtpc = cond ? pc_imm : pc + 64'd4;
            end
        endcase
    end

endmodule

/* hw/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               block,
    input  logic               valid_in,
    input  ex_pkg::ex_issue_t  issue,
    input  logic               raise_intr,
    output logic               valid,
    output ex_pkg::ex_result_t out
);

    ex_pkg::ex_issue_t       held;
    logic                    held_valid;
    logic [ex_pkg::xlen-1:0] imm_ext;
    logic [ex_pkg::xlen-1:0] op_a;
    logic [ex_pkg::xlen-1:0] op_b;
    logic [ex_pkg::xlen-1:0] alu_result;
    logic                    alu_zero;
    logic [ex_pkg::xlen-1:0] mdu_result;
    logic                    mdu_error;
    logic [ex_pkg::xlen-1:0] nxtpc;
    logic                    taken;

    always_ff @(posedge clk) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (!block) begin
            held_valid <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!block) begin
            held <= issue;
        end
    end

    assign imm_ext = {{32{held.imm[31]}}, held.imm};
    assign op_a = held.src_a_pc ? held.pc : held.src1;

    always_comb begin
        case (held.src_b)
            ex_pkg::sel_rs2:  op_b = held.src2;
            ex_pkg::sel_four: op_b = 64'd4;
            ex_pkg::sel_imm:  op_b = imm_ext;
            default:          op_b = held.csr_data;
        endcase
    end

    alu u_alu (
        .a      (op_a),
        .b      (op_b),
        .op     (held.alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    mul_div_unit u_mdu (
        .src1   (held.src1),
        .src2   (held.src2),
        .op     (held.mdu_op),
        .result (mdu_result),
        .error  (mdu_error)
    );

    // lt comes from bit 0 of the slt or sltu that decode picked.
    next_pc u_next_pc (
        .pc              (held.pc),
        .rs1_val         (held.src1),
        .imm             (imm_ext),
        .zero            (alu_zero),
        .lt              (alu_result[0]),
        .branch          (held.branch),
        .branch_unsigned (held.branch_unsigned),
        .nxtpc           (nxtpc),
        .taken           (taken)
    );

    // An interrupt hides the item but keeps it held.
    assign valid = held_valid && !raise_intr;

    always_comb begin
        out.result = held.use_mdu ? mdu_result : alu_result;
        out.nxtpc = nxtpc;
        out.is_jmp = held_valid && (taken || held.csr);
        out.rd = held.rd;
        out.csr_addr = held.csr_addr;
        out.mem_op = held.mem_op;
        out.mem_rd = held.mem_rd;
        out.mem_wr = held.mem_wr;
        out.reg_wr = held.reg_wr;
        out.csr = held.csr;
        out.ecall = held.ecall;
        out.mret = held.mret;
        out.done = held.done;
        out.error = held.error || (held.use_mdu && mdu_error);
    end

    a_block_holds: assert property (
        @(posedge clk) disable iff (reset)
        block && held_valid |=> $stable(held) && $stable(held_valid) && $stable(out)
    );

    a_no_valid_after_reset: assert property (
        @(posedge clk) reset |=> !valid
    );

    a_jmp_needs_valid: assert property (
        @(posedge clk) disable iff (reset) out.is_jmp |-> held_valid
    );

endmodule

/* testbench/tb_execute_stage.sv */
`timescale 1ns/1ps

module tb_execute_stage;

    localparam int vec_words = 17;
    localparam int max_vecs = 64;

    logic               clk;
    logic               reset;
    logic               block;
    logic               valid_in;
    logic               raise_intr;
    ex_pkg::ex_issue_t  issue;
    logic               valid;
    ex_pkg::ex_result_t out;

    logic [63:0] vec_mem [0:vec_words*max_vecs-1];
    int          vec_count;
    int          timeout_limit = 1000;
    int          cycle_count = 0;
    logic [15:0] lfsr_state;
    int          next_idx;
    int          offer_idx;
    int          model_idx;
    logic        model_valid;
    int          idle_cycles;
    logic        bit_a;
    logic        bit_b;

    execute_stage dut (
        .clk        (clk),
        .reset      (reset),
        .block      (block),
        .valid_in   (valid_in),
        .issue      (issue),
        .raise_intr (raise_intr),
        .valid      (valid),
        .out        (out)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout after %0d cycles, the vectors did not drain", cycle_count);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    end

    function automatic logic [63:0] fill_word(input int addr);
        return {32'hdead_beef, addr};
    endfunction

    // Galois form, mask 0xb400.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hb400;
        end
        return n;
    endfunction

    task random_bit(output logic b);
        b = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
    endtask

    task check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task load_vectors;
        for (int i = 0; i < vec_words * max_vecs; i++) begin
            vec_mem[i] = fill_word(i);
        end
        $readmemh("testbench/ex_tests.txt", vec_mem);
        vec_count = 0;
        while (vec_count < max_vecs &&
               vec_mem[vec_count * vec_words] != fill_word(vec_count * vec_words)) begin
            vec_count++;
        end
        if (vec_count == 0) begin
            $display("No test vectors were found in testbench/ex_tests.txt");
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    // Side fields come from index bits so a lost or doubled item shows.
    function automatic ex_pkg::ex_issue_t make_issue(input int idx);
        ex_pkg::ex_issue_t it;
        int base;
        base = idx * vec_words;
        it = '0;
        it.pc = vec_mem[base];
        it.src1 = vec_mem[base + 1];
        it.src2 = vec_mem[base + 2];
        it.imm = vec_mem[base + 3][31:0];
        it.csr_data = vec_mem[base + 4];
        it.src_a_pc = vec_mem[base + 5][0];
        it.src_b = ex_pkg::src_b_e'(vec_mem[base + 6][1:0]);
        it.use_mdu = vec_mem[base + 7][0];
        it.alu_op = ex_pkg::alu_op_e'(vec_mem[base + 8][4:0]);
        it.mdu_op = ex_pkg::mdu_op_e'(vec_mem[base + 9][3:0]);
        it.branch = ex_pkg::branch_e'(vec_mem[base + 10][2:0]);
        it.branch_unsigned = vec_mem[base + 11][0];
        it.csr = vec_mem[base + 12][0];
        it.rd = idx[4:0];
        it.csr_addr = idx[11:0];
        it.mem_op = ex_pkg::mem_op_e'(3'(idx % 7));
        it.mem_rd = idx[0];
        it.mem_wr = idx[1];
        it.reg_wr = !idx[0];
        it.ecall = idx[2];
        it.mret = idx[3];
        it.done = idx[4];
        return it;
    endfunction

    // What the stage register holds after this edge.
    task update_model;
        if (!block) begin
            model_valid = valid_in;
            model_idx = offer_idx;
            if (valid_in) begin
                next_idx++;
            end
        end
    endtask

    task drive_inputs;
        random_bit(bit_a);
        random_bit(bit_b);
        block <= bit_a & bit_b;
        random_bit(bit_a);
        random_bit(bit_b);
        raise_intr <= bit_a & bit_b;
        if (idle_cycles < 2) begin
            idle_cycles++;
            valid_in <= 1'b0;
        end else if (next_idx < vec_count) begin
            valid_in <= 1'b1;
            issue <= make_issue(next_idx);
            offer_idx = next_idx;
        end else begin
            valid_in <= 1'b0;
        end
    endtask

    task check_outputs;
        int base;
        base = model_idx * vec_words;
        check_value("valid", 64'(valid), 64'(model_valid && !raise_intr));
        if (model_valid) begin
            check_value("result", out.result, vec_mem[base + 13]);
            check_value("nxtpc", out.nxtpc, vec_mem[base + 14]);
            check_value("is_jmp", 64'(out.is_jmp), vec_mem[base + 15]);
            check_value("error", 64'(out.error), vec_mem[base + 16]);
            check_value("csr", 64'(out.csr), 64'(vec_mem[base + 12][0]));
            check_value("rd", 64'(out.rd), 64'(model_idx[4:0]));
            check_value("csr_addr", 64'(out.csr_addr), 64'(model_idx[11:0]));
            check_value("mem_op", 64'(out.mem_op), 64'(model_idx % 7));
            check_value("mem_rd", 64'(out.mem_rd), 64'(model_idx[0]));
            check_value("mem_wr", 64'(out.mem_wr), 64'(model_idx[1]));
            check_value("reg_wr", 64'(out.reg_wr), 64'(!model_idx[0]));
            check_value("ecall", 64'(out.ecall), 64'(model_idx[2]));
            check_value("mret", 64'(out.mret), 64'(model_idx[3]));
            check_value("done", 64'(out.done), 64'(model_idx[4]));
        end else begin
            check_value("is_jmp", 64'(out.is_jmp), 64'd0);
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        block = 1'b0;
        valid_in = 1'b0;
        raise_intr = 1'b0;
        issue = '0;
        lfsr_state = 16'd31;
        model_valid = 1'b0;
        model_idx = 0;
        next_idx = 0;
        offer_idx = 0;
        idle_cycles = 0;
        load_vectors();
        timeout_limit = 4 * vec_count + 50;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        // Outputs are checked mid-cycle, away from the driving edge.
        while (next_idx < vec_count || model_valid) begin
            @(posedge clk);
            update_model();
            drive_inputs();
            @(negedge clk);
            check_outputs();
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* all.f */
hw/ex_pkg.sv
hw/alu.sv
hw/mul_div_unit.sv
hw/next_pc.sv
hw/execute_stage.sv
testbench/tb_execute_stage.sv

/* Makefile */
# Verilator build and run for the execute stage testbench.
# Any variable below can be overridden, e.g. make run LOG=run1.log

VERILATOR ?= verilator
TOP       ?= tb_execute_stage
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= ALL CHECKS PASSED

SOURCES := $(wildcard hw/*.sv) $(wildcard testbench/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides the result, so a crash or $fatal also counts as failure.
run: compile
	./$(BINARY) | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/ex_tests.txt */
// pc src1 src2 imm csr_data src_a_pc src_b use_mdu alu_op mdu_op branch br_unsigned csr
// then expected result nxtpc is_jmp error, all fields in hex
1000 5 7 0 0 0 0 0 0 0 0 0 0 c 1004 0 0
1004 3 5 0 0 0 0 0 1 0 0 0 0 fffffffffffffffe 1008 0 0
1008 10 0 fffffff0 0 0 2 0 0 0 0 0 0 0 100c 0 0
100c 0 0 0 0 1 1 0 0 0 0 0 0 1010 1010 0 0
1010 0 0 0 12345678 0 3 0 f 0 0 0 1 12345678 1014 1 0
1014 8000000000000000 4 0 0 0 0 0 7 0 0 0 0 f800000000000000 1018 0 0
1018 7fffffff 1 0 0 0 0 0 a 0 0 0 0 ffffffff80000000 101c 0 0
101c 80000000 4 0 0 0 0 0 e 0 0 0 0 fffffffff8000000 1020 0 0
1020 ff 0 1c 0 0 2 0 c 0 0 0 0 fffffffff0000000 1024 0 0
1024 fffffffffffffffd 7 0 0 0 0 1 0 0 0 0 0 ffffffffffffffeb 1028 0 0
1028 ffffffffffffffff ffffffffffffffff 0 0 0 0 1 0 3 0 0 0 fffffffffffffffe 102c 0 0
102c ffffffffffffffff 2 0 0 0 0 1 0 1 0 0 0 ffffffffffffffff 1030 0 0
1030 2a 0 0 0 0 0 1 0 4 0 0 0 ffffffffffffffff 1034 0 0
1034 8000000000000000 ffffffffffffffff 0 0 0 0 1 0 4 0 0 0 8000000000000000 1038 0 0
1038 2a 0 0 0 0 0 1 0 7 0 0 0 2a 103c 0 0
103c fffffff9 2 0 0 0 0 1 0 9 0 0 0 fffffffffffffffd 1040 0 0
1040 5 5 40 0 0 0 0 1 0 3 0 0 0 1080 1 0
1080 ffffffffffffffff 1 fffffff8 0 0 0 0 3 0 5 0 0 1 1078 1 0
1078 ffffffffffffffff 1 10 0 0 0 0 4 0 6 1 0 0 1088 1 0
1088 0 0 100 0 1 1 0 0 0 1 0 0 108c 1188 1 0
1188 2001 0 10 0 1 1 0 0 0 2 0 0 118c 2010 1 0
2010 1 1 0 0 0 0 1 0 f 0 0 0 0 2014 0 1
